// File: include/memory_game_params.svh
`ifndef MEMORY_GAME_PARAMS_SVH
`define MEMORY_GAME_PARAMS_SVH

// --------------------------------------------------
// data widths
// --------------------------------------------------
`define MG_KEY_WIDTH 4      // one pattern on the four key switches
`define MG_INDEX_WIDTH 4    // round number or sequence address

// --------------------------------------------------
// game size and timing
// --------------------------------------------------
`define MG_SEQ_LENGTH 16    // rounds per game, also rom depth

// timeout counter, must hold MG_TIMEOUT_CYCLES-1
`define MG_TIMER_WIDTH 12
`define MG_TIMEOUT_CYCLES 3000  // wait cycles before the player loses

`endif

// File: hw/memory_game_pkg.sv
`default_nettype none

`include "memory_game_params.svh"

package memory_game_pkg;

  // --------------------------------------------------
  // vector types
  // --------------------------------------------------
  typedef logic [`MG_KEY_WIDTH-1:0] key_t;          // switch pattern or led pattern
  typedef logic [`MG_INDEX_WIDTH-1:0] index_t;      // round or address
  typedef logic [`MG_TIMER_WIDTH-1:0] timer_count_t;

  // --------------------------------------------------
  // control states
  // --------------------------------------------------
  // codes match the old debug display digits
  typedef enum logic [3:0] {
    idle        = 4'h0,
    wait_key    = 4'h1,  // waiting for a press, timer running
    round_start = 4'h2,
    prepare     = 4'h3,
    store_key   = 4'h4,
    compare     = 4'h5,
    next_key    = 4'h6,
    round_end   = 4'h7,
    next_round  = 4'h8,
    timed_out   = 4'hB,
    won         = 4'hD,
    lost        = 4'hE
  } game_state_t;

endpackage

`default_nettype wire

// File: hw/game_control.sv
`timescale 1ns/100ps
`default_nettype none

module game_control (
  input  logic clock,
  input  logic reset,
  input  logic start,
  input  logic key_pulse,       // new press seen
  input  logic key_match,       // stored key equals rom entry
  input  logic round_complete,  // address reached round
  input  logic last_round,
  input  logic timeout,
  output logic clear_address,
  output logic count_address,
  output logic clear_round,
  output logic count_round,
  output logic clear_key,
  output logic store_key,
  output logic clear_timer,
  output logic count_timer,
  output logic done,
  output logic won,
  output logic lost,
  output logic timed_out
);
  import memory_game_pkg::*;

  game_state_t state;
  game_state_t state_next;

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  // some state names clash with port names, hence the scoped references
  always_comb begin
    state_next = state;
    case (state)
      idle:        state_next = start ? prepare : idle;
      prepare:     state_next = round_start;
      round_start: state_next = wait_key;
      wait_key: begin
        // timeout wins over a press in the same cycle
        if (timeout) begin
          state_next = memory_game_pkg::timed_out;
        end else if (key_pulse) begin
          state_next = memory_game_pkg::store_key;
        end
      end
      memory_game_pkg::store_key: state_next = compare;
      compare: begin
        if (!key_match) begin
          state_next = memory_game_pkg::lost;
        end else if (round_complete) begin
          state_next = round_end;   // whole round entered
        end else begin
          state_next = next_key;
        end
      end
      next_key:    state_next = wait_key;
      round_end:   state_next = last_round ? memory_game_pkg::won : next_round;
      next_round:  state_next = round_start;
      // terminal states, start begins a new game
      memory_game_pkg::lost,
      memory_game_pkg::won,
      memory_game_pkg::timed_out: state_next = start ? prepare : state;
      default:     state_next = idle;  // unused codes
    endcase
  end

  // --------------------------------------------------
  // moore outputs
  // --------------------------------------------------
  assign clear_address = (state == idle) || (state == prepare) || (state == round_start);
  assign count_address = (state == next_key);
  assign clear_round   = (state == idle) || (state == prepare);
  assign count_round   = (state == next_round);
  assign clear_key     = (state == idle) || (state == prepare);
  assign store_key     = (state == memory_game_pkg::store_key);
  assign count_timer   = (state == wait_key);    // timer only runs while waiting
  assign clear_timer   = (state == idle) || (state == prepare) ||
                         (state == round_start) || (state == next_key);

  // result flags
  assign won       = (state == memory_game_pkg::won);
  assign timed_out = (state == memory_game_pkg::timed_out);
  assign lost      = (state == memory_game_pkg::lost) || timed_out;  // timeout counts as a loss
  assign done      = won || lost;

endmodule

`default_nettype wire

// File: hw/play_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "memory_game_params.svh"

module play_timer #(
  parameter int timeout_cycles = `MG_TIMEOUT_CYCLES
) (
  input  logic clock,
  input  logic reset,
  input  logic clear_timer,   // synchronous clear
  input  logic count_timer,
  output logic timeout
);
  import memory_game_pkg::*;

  localparam timer_count_t last_count = timer_count_t'(timeout_cycles - 1);

  timer_count_t count;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (clear_timer) begin
      count <= '0;
    end else if (count_timer) begin
      if (count == last_count) begin
        count <= '0;   // wrap at terminal count
      end else begin
        count <= count + timer_count_t'(1);
      end
    end
  end

  assign timeout = (count == last_count);  // terminal count flag

endmodule

`default_nettype wire

// File: hw/sequence_counters.sv
`timescale 1ns/100ps
`default_nettype none

`include "memory_game_params.svh"

module sequence_counters (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clear_address,
  input  logic                    count_address,
  input  logic                    clear_round,
  input  logic                    count_round,
  output memory_game_pkg::index_t address,         // position inside the round
  output memory_game_pkg::index_t round,           // current round number
  output logic                    round_complete,
  output logic                    last_round
);
  import memory_game_pkg::*;

  // --------------------------------------------------
  // address counter
  // --------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      address <= '0;
    end else if (clear_address) begin
      address <= '0;
    end else if (count_address) begin
      address <= address + index_t'(1);
    end
  end

  // --------------------------------------------------
  // round counter
  // --------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      round <= '0;
    end else if (clear_round) begin
      round <= '0;
    end else if (count_round) begin
      round <= round + index_t'(1);
    end
  end

  // flags straight from the counter values
  assign round_complete = (address == round);                         // entries 0..round done
  assign last_round     = (round == index_t'(`MG_SEQ_LENGTH - 1));

endmodule

`default_nettype wire

// File: hw/sequence_rom.sv
`timescale 1ns/100ps
`default_nettype none

module sequence_rom (
  input  logic                  clock,
  input  memory_game_pkg::index_t address,      // compare port
  input  memory_game_pkg::index_t round,        // display port
  output memory_game_pkg::key_t expected_key,
  output memory_game_pkg::key_t display_key
);
  import memory_game_pkg::*;

  // fixed key sequence, one-hot patterns for the four switches
  function automatic key_t rom_entry(input index_t index);
    case (index)
      4'h0: rom_entry = 4'h1;
      4'h1: rom_entry = 4'h2;
      4'h2: rom_entry = 4'h4;
      4'h3: rom_entry = 4'h8;
      4'h4: rom_entry = 4'h4;
      4'h5: rom_entry = 4'h2;
      4'h6: rom_entry = 4'h1;
      4'h7: rom_entry = 4'h1;
      4'h8: rom_entry = 4'h2;
      4'h9: rom_entry = 4'h2;
      4'hA: rom_entry = 4'h4;
      4'hB: rom_entry = 4'h4;
      4'hC: rom_entry = 4'h8;
      4'hD: rom_entry = 4'h8;
      4'hE: rom_entry = 4'h1;
      4'hF: rom_entry = 4'h4;
    endcase
  endfunction

  // --------------------------------------------------
  // registered read ports
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    expected_key <= rom_entry(address);  // checked against the stored key
  end

  always_ff @(posedge clock) begin
    display_key <= rom_entry(round);     // newest entry of the round, to leds
  end

endmodule

`default_nettype wire

// File: hw/key_capture.sv
`timescale 1ns/100ps
`default_nettype none

module key_capture (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear_key,
  input  logic                  store_key,
  input  memory_game_pkg::key_t keys,          // raw switches
  input  memory_game_pkg::key_t expected_key,  // from the rom
  output logic                  key_pulse,
  output logic                  key_match
);
  import memory_game_pkg::*;

  logic any_key;
  logic any_key_q;    // first sample
  logic any_key_qq;   // one cycle older
  key_t key_reg;

  assign any_key = |keys;

  // --------------------------------------------------
  // press edge detector
  // --------------------------------------------------
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      any_key_q  <= 1'b0;
      any_key_qq <= 1'b0;
    end else begin
      any_key_q  <= any_key;
      any_key_qq <= any_key_q;
    end
  end

  assign key_pulse = any_key_q && !any_key_qq;  // one pulse per press, held keys ignored

  // --------------------------------------------------
  // key register
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (clear_key) begin
      key_reg <= '0;
    end else if (store_key) begin
      key_reg <= keys;   // keys still held here
    end
  end

  assign key_match = (key_reg == expected_key);

endmodule

`default_nettype wire

// File: hw/memory_game.sv
`timescale 1ns/100ps
`default_nettype none

`include "memory_game_params.svh"

module memory_game #(
  parameter int timeout_cycles = `MG_TIMEOUT_CYCLES
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  start,
  input  memory_game_pkg::key_t keys,
  output memory_game_pkg::key_t leds,   // newest entry of the round
  output logic                  done,
  output logic                  won,
  output logic                  lost,
  output logic                  timed_out
);
  import memory_game_pkg::*;

  // control strobes
  logic clear_address;
  logic count_address;
  logic clear_round;
  logic count_round;
  logic clear_key;
  logic store_key;
  logic clear_timer;
  logic count_timer;

  // status back to control
  logic key_pulse;
  logic key_match;
  logic round_complete;
  logic last_round;
  logic timeout;

  // datapath
  index_t address;
  index_t round;
  key_t   expected_key;

  // --------------------------------------------------
  // control
  // --------------------------------------------------
  game_control u_game_control (
    .clock          (clock),
    .reset          (reset),
    .start          (start),
    .key_pulse      (key_pulse),
    .key_match      (key_match),
    .round_complete (round_complete),
    .last_round     (last_round),
    .timeout        (timeout),
    .clear_address  (clear_address),
    .count_address  (count_address),
    .clear_round    (clear_round),
    .count_round    (count_round),
    .clear_key      (clear_key),
    .store_key      (store_key),
    .clear_timer    (clear_timer),
    .count_timer    (count_timer),
    .done           (done),
    .won            (won),
    .lost           (lost),
    .timed_out      (timed_out)
  );

  play_timer #(
    .timeout_cycles (timeout_cycles)
  ) u_play_timer (
    .clock       (clock),
    .reset       (reset),
    .clear_timer (clear_timer),
    .count_timer (count_timer),
    .timeout     (timeout)
  );

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  sequence_counters u_sequence_counters (
    .clock          (clock),
    .reset          (reset),
    .clear_address  (clear_address),
    .count_address  (count_address),
    .clear_round    (clear_round),
    .count_round    (count_round),
    .address        (address),
    .round          (round),
    .round_complete (round_complete),
    .last_round     (last_round)
  );

  sequence_rom u_sequence_rom (
    .clock        (clock),
    .address      (address),
    .round        (round),
    .expected_key (expected_key),
    .display_key  (leds)          // display port drives the board leds
  );

  key_capture u_key_capture (
    .clock        (clock),
    .reset        (reset),
    .clear_key    (clear_key),
    .store_key    (store_key),
    .keys         (keys),
    .expected_key (expected_key),
    .key_pulse    (key_pulse),
    .key_match    (key_match)
  );

endmodule

`default_nettype wire

// File: test/memory_game_checker.sv
`timescale 1ns/100ps
`default_nettype none

module memory_game_checker (
  input logic clock,
  input logic reset,
  input logic done,
  input logic won,
  input logic lost,
  input logic timed_out
);

  int failure_count = 0;  // polled by the testbench

  // --------------------------------------------------
  // result flag consistency
  // --------------------------------------------------
  won_lost_exclusive: assert property (@(posedge clock) disable iff (reset) !(won && lost))
    else begin
      failure_count++;
      $error("won and lost high in the same cycle");
    end

  done_is_result: assert property (@(posedge clock) disable iff (reset) done == (won || lost))
    else begin
      failure_count++;
      $error("done does not match won or lost");
    end

  timeout_is_loss: assert property (@(posedge clock) disable iff (reset) timed_out |-> lost)
    else begin
      failure_count++;
      $error("timed_out high without lost");
    end

  // fsm leaves reset in idle
  done_low_after_reset: assert property (@(posedge clock) $fell(reset) |-> !done)
    else begin
      failure_count++;
      $error("done high right after reset release");
    end

endmodule

bind memory_game memory_game_checker u_memory_game_checker (
  .clock     (clock),
  .reset     (reset),
  .done      (done),
  .won       (won),
  .lost      (lost),
  .timed_out (timed_out)
);

`default_nettype wire

// File: test/memory_game_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "memory_game_params.svh"

module memory_game_tb;
  import memory_game_pkg::*;

  localparam int clock_period    = 20;
  localparam int timeout_cycles  = 200;   // short timeout for simulation
  localparam int plays_per_game  = 136;   // 1 + 2 + ... + 16
  localparam int watchdog_cycles = 2 * plays_per_game * 12 + 4 * timeout_cycles + 1000;

  // reference key sequence
  localparam key_t sequence_table [`MG_SEQ_LENGTH] = '{
    4'h1, 4'h2, 4'h4, 4'h8, 4'h4, 4'h2, 4'h1, 4'h1,
    4'h2, 4'h2, 4'h4, 4'h4, 4'h8, 4'h8, 4'h1, 4'h4
  };

  logic clock;
  logic reset;
  logic start;
  key_t keys;
  key_t leds;
  logic done;
  logic won;
  logic lost;
  logic timed_out;

  // expected values handed to the compare processes
  index_t tracked_round;
  logic   exp_done;
  logic   exp_won;
  logic   exp_lost;
  logic   exp_timed_out;
  event   round_entered;
  event   result_ready;

  memory_game #(
    .timeout_cycles (timeout_cycles)
  ) u_memory_game (
    .clock     (clock),
    .reset     (reset),
    .start     (start),
    .keys      (keys),
    .leds      (leds),
    .done      (done),
    .won       (won),
    .lost      (lost),
    .timed_out (timed_out)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  // --------------------------------------------------
  // reference and compare tasks
  // --------------------------------------------------
  function automatic key_t expected_key(input index_t index);
    return sequence_table[index];
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "stopping at first failure");
  endtask

  task automatic check_leds(input string name, input key_t expected, input key_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_index(input string name, input index_t expected, input index_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // leds and round counter at each round entry
  always @(round_entered) begin
    check_leds("leds", expected_key(tracked_round), leds);
    check_index("round", tracked_round, u_memory_game.round);
  end

  always @(result_ready) begin
    check_flag("done", exp_done, done);
    check_flag("won", exp_won, won);
    check_flag("lost", exp_lost, lost);
    check_flag("timed_out", exp_timed_out, timed_out);
  end

  // bound assertions count their failures
  always @(negedge clock) begin
    if (u_memory_game.u_memory_game_checker.failure_count != 0) begin
      $display("a concurrent assertion in the checker failed");
      stop_with_failure();
    end
  end

  // --------------------------------------------------
  // stimulus tasks, all entered on a falling edge
  // --------------------------------------------------
  task automatic expect_result(input logic d, input logic w, input logic l, input logic t);
    exp_done      = d;
    exp_won       = w;
    exp_lost      = l;
    exp_timed_out = t;
    -> result_ready;
  endtask

  // hold 3 cycles, release 3 cycles
  task automatic press_key(input key_t pattern);
    keys = pattern;
    repeat (3) @(negedge clock);
    keys = '0;
    repeat (3) @(negedge clock);
  endtask

  task automatic start_game();
    start = 1'b1;
    @(negedge clock);
    start = 1'b0;
    expect_result(1'b0, 1'b0, 1'b0, 1'b0);  // prepare clears the flags
  endtask

  // let round counter and rom settle, then sample
  task automatic announce_round(input index_t round_number);
    repeat (2) @(negedge clock);
    tracked_round = round_number;
    -> round_entered;
  endtask

  task automatic enter_round(input index_t round_number);
    announce_round(round_number);
    for (int i = 0; i <= int'(round_number); i++) begin
      press_key(expected_key(index_t'(i)));
    end
  endtask

  task automatic wait_for_done(input int limit);
    int waited;
    waited = 0;
    while (!done && waited < limit) begin
      @(negedge clock);
      waited++;
    end
    if (!done) begin
      $display("done did not rise within %0d cycles", limit);
      stop_with_failure();
    end
  endtask

  task automatic play_full_game();
    start_game();
    for (int r = 0; r < `MG_SEQ_LENGTH; r++) begin
      enter_round(index_t'(r));
    end
    wait_for_done(20);
    expect_result(1'b1, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic play_wrong_key_game();
    int unsigned bad_round;
    int unsigned bad_position;
    key_t        right_key;
    key_t        flip;
    bad_round    = $urandom % `MG_SEQ_LENGTH;
    bad_position = $urandom % (bad_round + 1);
    start_game();
    for (int r = 0; r < int'(bad_round); r++) begin
      enter_round(index_t'(r));
    end
    announce_round(index_t'(bad_round));
    for (int i = 0; i < int'(bad_position); i++) begin
      press_key(expected_key(index_t'(i)));
    end
    right_key = expected_key(index_t'(bad_position));
    do begin
      flip = key_t'($urandom % 15 + 1);
    end while ((right_key ^ flip) == '0);  // an all-zero pattern is no press
    press_key(right_key ^ flip);
    wait_for_done(20);
    expect_result(1'b1, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic play_timeout_game();
    start_game();
    enter_round('0);              // one correct play
    announce_round(index_t'(1));  // then the player stalls
    wait_for_done(timeout_cycles + 50);
    expect_result(1'b1, 1'b0, 1'b1, 1'b1);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(47));
    reset         = 1'b1;
    start         = 1'b0;
    keys          = '0;
    tracked_round = '0;
    exp_done      = 1'b0;
    exp_won       = 1'b0;
    exp_lost      = 1'b0;
    exp_timed_out = 1'b0;
    repeat (2) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    -> round_entered;             // leds show entry 0
    expect_result(1'b0, 1'b0, 1'b0, 1'b0);

    play_full_game();
    play_wrong_key_game();        // restarts from won
    play_timeout_game();          // restarts from lost
    play_full_game();             // restarts from timed_out
    repeat (2) @(negedge clock);  // let the last checks run

    if (u_memory_game.u_memory_game_checker.failure_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("checker reported %0d assertion failures",
               u_memory_game.u_memory_game_checker.failure_count);
      stop_with_failure();
    end
  end

  // watchdog, sized from the longest expected run
  initial begin
    #(watchdog_cycles * clock_period);
    $display("watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    stop_with_failure();
  end

endmodule

`default_nettype wire

// File: memory_game.f
+incdir+include
hw/memory_game_pkg.sv
hw/game_control.sv
hw/play_timer.sv
hw/sequence_counters.sv
hw/sequence_rom.sv
hw/key_capture.sv
hw/memory_game.sv
test/memory_game_checker.sv
test/memory_game_tb.sv
